/* m72_io_input.txt */
# op a b c d e in hex: K code pressed panel | J joy0 joy1 panel | D addr byte dip mask
# W even_addr lo hi exp_addr exp_data | C rnw addr wdata exp_rdata during_rom_download
K 75 1 7F7FF 0 0
K 14 1 7777F 0 0
K 99 1 7777F 0 0
K 75 0 F7F7F 0 0
K 14 0 FFFFF 0 0
K 2E 1 FFFFB 0 0
K 2E 0 FFFFF 0 0
J 0009 0000 6FFFF 0 0
J 0010 0102 F7DFE 0 0
K 11 1 F3DBE 0 0
J 0600 0000 FBFB9 0 0
K 11 0 FFFF9 0 0
J 0000 0000 FFFFF 0 0
D 01 3C C300 FF00 0
D 00 A5 C35A FFFF 0
D 08 FF C35A FFFF 0
D 05 11 C35A FFFF 0
W 000100 34 12 000100 1234
W 000102 CD AB 000102 ABCD
W 1FFFFFE 01 80 1FFFFFE 8001
C 1 000100 0000 1234 0
C 0 000200 BEEF 0000 0
C 1 000200 0000 BEEF 0
C 1 1FFFFFE 0000 8001 1
C 0 000102 5555 0000 1
C 1 000102 0000 5555 0

/* compile.f */
+incdir+.
m72_pkg.sv
arcade_inputs.sv
rom_word_packer.sv
sdram_ch3_arbiter.sv
m72_io_top.sv
tb_m72_io.sv

/* Makefile */
# Verilator build and run, every variable can be set on the command line
VERILATOR ?= verilator
TOP       ?= tb_m72_io
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) m72_defs.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) m72_io_input.txt
	-$(abspath $(SIM_BIN)) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_m72_io.sv */
// Runs from the project root, memory answers after 1 to 4 cycles and ignores byte enables
`timescale 1ns/1ps

module tb_m72_io;

    logic                 CLK_32M = 1'b0;
    logic                 rst_n;
    logic                 ioctl_download;
    m72_pkg::dl_index_t   ioctl_index;
    logic                 ioctl_wr;
    m72_pkg::mem_addr_t   ioctl_addr;
    logic [7:0]           ioctl_dout;
    logic                 ioctl_wait;
    m72_pkg::ps2_key_t    ps2_key;
    m72_pkg::joy_t        joystick_0;
    m72_pkg::joy_t        joystick_1;
    m72_pkg::mem_req_t    cpu_req;
    m72_pkg::mem_data_t   cpu_dout;
    logic                 cpu_rdy;
    m72_pkg::mem_req_t    mem;
    m72_pkg::mem_data_t   mem_dout = '0;
    logic                 mem_rdy = 1'b0;
    m72_pkg::panel_t      panel;
    logic [15:0]          dip_sw;

    integer           seed = 32'h32fa;
    int               cycles = 0;
    int               cycle_limit = 1000;    // Replaced once the vectors are counted
    logic [7:0]       op_q[$];
    logic [4:0][31:0] arg_q[$];
    logic [19:0]      exp_panel;             // Last panel value the vectors promised

    m72_io_top i_m72_io_top (.*);

    always #50 CLK_32M = ~CLK_32M;

    always @(posedge CLK_32M) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            stop_with_error("run did not finish within the cycle limit");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    m72_pkg::mem_req_t  mem_seen;
    m72_pkg::mem_req_t  cur;
    logic               busy = 1'b0;
    int                 lat;
    logic [15:0]        store [logic [24:0]];

    always @(posedge CLK_32M) mem_seen <= mem;   // Request as held through the cycle

    function automatic logic [15:0] read_word(input logic [24:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        return a[15:0] ^ {7'd0, a[24:16]};       // Unwritten words
    endfunction

    always @(negedge CLK_32M) begin : memory_model
        if (!rst_n) begin
            mem_rdy = 1'b0;
            busy    = 1'b0;
        end else if (mem_rdy) begin
            mem_rdy = 1'b0;                      // One-cycle ready pulse
        end else if (busy) begin
            lat = lat - 1;
            if (lat == 0) begin
                busy    = 1'b0;
                mem_rdy = 1'b1;
                if (cur.rnw) begin
                    mem_dout = read_word(cur.addr);
                end else begin
                    store[cur.addr] = cur.wdata;
                end
            end
        end else if (mem_seen.req) begin
            cur  = mem_seen;
            busy = 1'b1;
            lat  = 1 + int'($unsigned($random(seed)) % 4);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string why);
        $display("ERROR: %s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic load_vectors;
        int                fd;
        int                n;
        logic [63:0]       tok;
        logic [8*128-1:0]  rest;
        logic [31:0]       a0, a1, a2, a3, a4;
        fd = $fopen("m72_io_input.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open m72_io_input.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tok);
                if (n == 1 && tok[7:0] == "#") begin
                    n = $fgets(rest, fd);            // Skip comment line
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
                    if (n != 5) begin
                        stop_with_error("vector line has fewer than five fields");
                    end else begin
                        op_q.push_back(tok[7:0]);
                        arg_q.push_back({a4, a3, a2, a1, a0});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic key_event(input logic [7:0] code, input logic pressed,
                             input logic [19:0] exp_val);
        @(negedge CLK_32M);
        ps2_key = {~ps2_key[10], pressed, 1'b0, code};
        #25;
        check_value("panel before edge", 32'(panel), 32'(exp_panel));
        @(negedge CLK_32M);
        #25;
        check_value("panel", 32'(panel), 32'(exp_val));
        exp_panel = exp_val;
    endtask

    task automatic joy_set(input logic [15:0] j0, input logic [15:0] j1,
                           input logic [19:0] exp_val);
        @(negedge CLK_32M);
        joystick_0 = j0;
        joystick_1 = j1;
        #25;                                     // Combinational path
        check_value("panel", 32'(panel), 32'(exp_val));
        exp_panel = exp_val;
    endtask

    task automatic dip_write(input logic [24:0] addr, input logic [7:0] data,
                             input logic [15:0] exp_val, input logic [15:0] mask);
        @(negedge CLK_32M);
        ioctl_download = 1'b1;
        ioctl_index    = 8'hFE;
        ioctl_addr     = addr;
        ioctl_dout     = data;
        ioctl_wr       = 1'b1;
        @(negedge CLK_32M);
        ioctl_wr       = 1'b0;
        ioctl_download = 1'b0;
        #25;
        check_value("dip_sw", 32'(dip_sw & mask), 32'(exp_val & mask));
    endtask

    task automatic rom_pair(input logic [24:0] addr, input logic [7:0] lo,
                            input logic [7:0] hi, input logic [24:0] exp_addr,
                            input logic [15:0] exp_data);
        @(negedge CLK_32M);
        ioctl_download = 1'b1;
        ioctl_index    = 8'h00;
        ioctl_addr     = addr;
        ioctl_dout     = lo;
        ioctl_wr       = 1'b1;
        @(negedge CLK_32M);
        ioctl_addr = addr | 25'd1;
        ioctl_dout = hi;
        #25;
        check_value("ioctl_wait", 32'(ioctl_wait), 32'd0);
        @(negedge CLK_32M);
        ioctl_wr = 1'b0;
        #25;
        check_value("mem.req", 32'(mem.req), 32'd1);
        check_value("mem.addr", 32'(mem.addr), 32'(exp_addr));
        check_value("mem.wdata", 32'(mem.wdata), 32'(exp_data));
        check_value("mem.be", 32'(mem.be), 32'd3);
        check_value("mem.rnw", 32'(mem.rnw), 32'd0);
        check_value("ioctl_wait", 32'(ioctl_wait), 32'd1);
        while (!mem_rdy) begin
            @(negedge CLK_32M);
            #25;
            check_value("ioctl_wait", 32'(ioctl_wait), 32'd1);
        end
        check_value("cpu_rdy", 32'(cpu_rdy), 32'd0);
        @(negedge CLK_32M);
        ioctl_download = 1'b0;
        #25;
        check_value("ioctl_wait", 32'(ioctl_wait), 32'd0);
        check_value("mem.req", 32'(mem.req), 32'd0);
    endtask

    task automatic cpu_access(input logic rnw, input logic [24:0] addr,
                              input logic [15:0] wdata, input logic [15:0] exp_rdata,
                              input logic during_dl);
        @(negedge CLK_32M);
        if (during_dl) begin
            ioctl_download = 1'b1;
            ioctl_index    = 8'h00;
        end
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.be    = 2'b11;
        cpu_req.rnw   = rnw;
        cpu_req.req   = 1'b1;
        if (during_dl) begin
            repeat (4) begin                     // CPU locked out while ROM loads
                #25;
                check_value("mem.req", 32'(mem.req), 32'd0);
                check_value("cpu_rdy", 32'(cpu_rdy), 32'd0);
                @(negedge CLK_32M);
            end
            ioctl_download = 1'b0;
        end
        #25;
        check_value("mem.req", 32'(mem.req), 32'd1);
        check_value("mem.addr", 32'(mem.addr), 32'(addr));
        check_value("mem.rnw", 32'(mem.rnw), 32'(rnw));
        if (!rnw) begin
            check_value("mem.wdata", 32'(mem.wdata), 32'(wdata));
        end
        while (!cpu_rdy) begin
            @(negedge CLK_32M);
            #25;
        end
        if (rnw) begin
            check_value("cpu_dout", 32'(cpu_dout), 32'(exp_rdata));
        end
        @(negedge CLK_32M);
        cpu_req = '0;
    endtask

    initial begin : run_tests
        logic [7:0]       op;
        logic [4:0][31:0] a;
        rst_n          = 1'b0;
        ioctl_download = 1'b0;
        ioctl_index    = '0;
        ioctl_wr       = 1'b0;
        ioctl_addr     = '0;
        ioctl_dout     = '0;
        ps2_key        = '0;
        joystick_0     = '0;
        joystick_1     = '0;
        cpu_req        = '0;
        exp_panel      = 20'hFFFFF;              // Nothing pressed
        load_vectors();
        cycle_limit = 40 * op_q.size();
        if (op_q.size() == 0) begin
            stop_with_error("vector file holds no operations");
        end
        repeat (3) @(negedge CLK_32M);
        rst_n = 1'b1;
        #25;
        check_value("ioctl_wait", 32'(ioctl_wait), 32'd0);
        check_value("mem.req", 32'(mem.req), 32'd0);
        check_value("cpu_rdy", 32'(cpu_rdy), 32'd0);
        check_value("panel", 32'(panel), 32'(exp_panel));
        while (op_q.size() > 0) begin
            op = op_q.pop_front();
            a  = arg_q.pop_front();
            case (op)
                "K": key_event(a[0][7:0], a[1][0], a[2][19:0]);
                "J": joy_set(a[0][15:0], a[1][15:0], a[2][19:0]);
                "D": dip_write(a[0][24:0], a[1][7:0], a[2][15:0], a[3][15:0]);
                "W": rom_pair(a[0][24:0], a[1][7:0], a[2][7:0], a[3][24:0], a[4][15:0]);
                "C": cpu_access(a[0][0], a[1][24:0], a[2][15:0], a[3][15:0], a[4][0]);
                default: stop_with_error("unknown operation code in the vector file");
            endcase
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* m72_io_top.sv */
// Single clock domain on CLK_32M, the CPU port must follow the hold-until-ready rule
`timescale 1ns/1ps
`include "m72_defs.svh"

module m72_io_top (
    input  logic                        CLK_32M,
    input  logic                        rst_n,
    // Host download
    input  logic                        ioctl_download,
    input  m72_pkg::dl_index_t          ioctl_index,
    input  logic                        ioctl_wr,
    input  m72_pkg::mem_addr_t          ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    output logic                        ioctl_wait,
    // Player inputs
    input  m72_pkg::ps2_key_t           ps2_key,
    input  m72_pkg::joy_t               joystick_0,
    input  m72_pkg::joy_t               joystick_1,
    // CPU port
    input  m72_pkg::mem_req_t           cpu_req,
    output m72_pkg::mem_data_t          cpu_dout,
    output logic                        cpu_rdy,
    // Memory channel
    output m72_pkg::mem_req_t           mem,
    input  m72_pkg::mem_data_t          mem_dout,
    input  logic                        mem_rdy,
    // Board side
    output m72_pkg::panel_t             panel,
    output logic [8*`M72_DIP_OUT-1:0]   dip_sw
);

    m72_pkg::mem_req_t rom_req;
    logic              rom_rdy;
    logic              rom_active;

    assign rom_active = ioctl_download
                     && (ioctl_index == m72_pkg::dl_index_t'(`M72_ROM_INDEX));

    assign cpu_dout = mem_dout;  // Only the CPU reads

    arcade_inputs i_inputs (
        .CLK_32M     (CLK_32M),
        .rst_n       (rst_n),
        .ps2_key     (ps2_key),
        .joystick_0  (joystick_0),
        .joystick_1  (joystick_1),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .panel       (panel),
        .dip_sw      (dip_sw)
    );

    rom_word_packer i_packer (
        .CLK_32M     (CLK_32M),
        .rst_n       (rst_n),
        .ioctl_wr    (ioctl_wr),
        .ioctl_index (ioctl_index),
        .ioctl_addr  (ioctl_addr),
        .ioctl_dout  (ioctl_dout),
        .ioctl_wait  (ioctl_wait),
        .rom_req     (rom_req),
        .rom_rdy     (rom_rdy)
    );

    sdram_ch3_arbiter i_arbiter (
        .CLK_32M     (CLK_32M),
        .rst_n       (rst_n),
        .rom_active  (rom_active),
        .rom_req     (rom_req),
        .rom_rdy     (rom_rdy),
        .cpu_req     (cpu_req),
        .cpu_rdy     (cpu_rdy),
        .mem         (mem),
        .mem_rdy     (mem_rdy)
    );

endmodule

/* sdram_ch3_arbiter.sv */
// Clients must hold each request steady until the ready pulse and drop it the cycle after
`timescale 1ns/1ps

module sdram_ch3_arbiter (
    input  logic               CLK_32M,
    input  logic               rst_n,
    input  logic               rom_active,
    input  m72_pkg::mem_req_t  rom_req,
    output logic               rom_rdy,
    input  m72_pkg::mem_req_t  cpu_req,
    output logic               cpu_rdy,
    output m72_pkg::mem_req_t  mem,
    input  logic               mem_rdy
);

    m72_pkg::arb_state_e state_q, state_d;
    logic pick_rom, pick_cpu;
    logic sel_rom, sel_cpu;

    // ROM wins during its download, CPU is locked out meanwhile
    assign pick_rom = rom_req.req && (rom_active || !cpu_req.req);
    assign pick_cpu = cpu_req.req && !rom_active;

    assign sel_rom = (state_q == m72_pkg::rom_busy) || ((state_q == m72_pkg::idle) && pick_rom);
    assign sel_cpu = (state_q == m72_pkg::cpu_busy) || ((state_q == m72_pkg::idle) && pick_cpu);

    always_comb begin
        state_d = state_q;
        case (state_q)
            m72_pkg::idle: begin
                if (pick_rom) begin
                    state_d = m72_pkg::rom_busy;
                end else if (pick_cpu) begin
                    state_d = m72_pkg::cpu_busy;
                end
            end
            m72_pkg::rom_busy, m72_pkg::cpu_busy: begin
                if (mem_rdy) begin
                    state_d = m72_pkg::idle;
                end
            end
            default: state_d = m72_pkg::idle;
        endcase
    end

    always_ff @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= m72_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Same-cycle pass-through of the granted client
    assign mem     = sel_rom ? rom_req : (sel_cpu ? cpu_req : '0);
    assign rom_rdy = sel_rom && mem_rdy;
    assign cpu_rdy = sel_cpu && mem_rdy;

    // Memory answers only an accepted request
    a_rdy_when_busy: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        mem_rdy |-> (state_q != m72_pkg::idle)
    ) else $error("mem_rdy with no granted request");

    // Granted client keeps its request steady until ready
    a_grant_stable: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        (mem.req && !mem_rdy) |=> $stable(mem)
    ) else $error("Granted request changed before ready");

endmodule

/* rom_word_packer.sv */
// Expects ROM bytes in address order, even byte before odd, and no host strobe while waiting
`timescale 1ns/1ps
`include "m72_defs.svh"

module rom_word_packer (
    input  logic                CLK_32M,
    input  logic                rst_n,
    input  logic                ioctl_wr,
    input  m72_pkg::dl_index_t  ioctl_index,
    input  m72_pkg::mem_addr_t  ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    output logic                ioctl_wait,
    output m72_pkg::mem_req_t   rom_req,
    input  logic                rom_rdy
);

    logic               rom_wr;
    logic [7:0]         lo_byte_q;   // Even byte awaiting its partner
    m72_pkg::mem_addr_t addr_q;
    m72_pkg::mem_data_t data_q;
    logic               pending_q;

    assign rom_wr = ioctl_wr && (ioctl_index == m72_pkg::dl_index_t'(`M72_ROM_INDEX));

    // Word assembly
    always_ff @(posedge CLK_32M) begin
        if (rom_wr && !ioctl_addr[0]) begin
            lo_byte_q <= ioctl_dout;
        end
        if (rom_wr && ioctl_addr[0]) begin
            addr_q <= {ioctl_addr[`M72_ADDR_W-1:1], 1'b0};
            data_q <= {ioctl_dout, lo_byte_q};
        end
    end

    // Write pending from odd byte until ready
    always_ff @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else begin
            if (rom_rdy) begin
                pending_q <= 1'b0;
            end
            if (rom_wr && ioctl_addr[0]) begin
                pending_q <= 1'b1;
            end
        end
    end

    assign rom_req = '{
        addr:  addr_q,
        wdata: data_q,
        be:    {`M72_BE_W{1'b1}},
        rnw:   1'b0,
        req:   pending_q
    };

    assign ioctl_wait = pending_q;  // Host holds off while the word is in flight

    // Host must respect back-pressure across the whole memory round trip
    a_no_strobe_in_wait: assert property (
        @(posedge CLK_32M) disable iff (!rst_n)
        ioctl_wait |-> !rom_wr
    ) else $error("ROM strobe while ioctl_wait is high");

endmodule

/* arcade_inputs.sv */
// Keyboard codes are PS/2 set 2, only DIP banks 0 and 1 reach the board and coin 2 is keys only
`timescale 1ns/1ps
`include "m72_defs.svh"

module arcade_inputs (
    input  logic                        CLK_32M,
    input  logic                        rst_n,
    input  m72_pkg::ps2_key_t           ps2_key,
    input  m72_pkg::joy_t               joystick_0,
    input  m72_pkg::joy_t               joystick_1,
    input  logic                        ioctl_wr,
    input  m72_pkg::dl_index_t          ioctl_index,
    input  m72_pkg::mem_addr_t          ioctl_addr,
    input  logic [7:0]                  ioctl_dout,
    output m72_pkg::panel_t             panel,
    output logic [8*`M72_DIP_OUT-1:0]   dip_sw
);

    localparam int dip_aw = $clog2(`M72_DIP_BANKS);

    //////////////////////////////////////////////////////////////////////
    // Keyboard event decoder
    //////////////////////////////////////////////////////////////////////

    logic key_tgl_q;
    logic key_event;
    logic btn_up, btn_down, btn_left, btn_right;
    logic btn_a, btn_b, btn_x, btn_y;
    logic btn_coin1, btn_coin2, btn_start1, btn_start2;
    m72_pkg::joy_t joy_any;

    assign key_event = ps2_key[10] != key_tgl_q;  // Host flips bit 10 per event

    always_ff @(posedge CLK_32M or negedge rst_n) begin
        if (!rst_n) begin
            key_tgl_q  <= 1'b0;
            btn_up     <= 1'b0;
            btn_down   <= 1'b0;
            btn_left   <= 1'b0;
            btn_right  <= 1'b0;
            btn_a      <= 1'b0;
            btn_b      <= 1'b0;
            btn_x      <= 1'b0;
            btn_y      <= 1'b0;
            btn_coin1  <= 1'b0;
            btn_coin2  <= 1'b0;
            btn_start1 <= 1'b0;
            btn_start2 <= 1'b0;
        end else begin
            key_tgl_q <= ps2_key[10];
            if (key_event) begin
                case (ps2_key[7:0])
                    `M72_KEY_UP:     btn_up     <= ps2_key[9];
                    `M72_KEY_DOWN:   btn_down   <= ps2_key[9];
                    `M72_KEY_LEFT:   btn_left   <= ps2_key[9];
                    `M72_KEY_RIGHT:  btn_right  <= ps2_key[9];
                    `M72_KEY_A:      btn_a      <= ps2_key[9];
                    `M72_KEY_B:      btn_b      <= ps2_key[9];
                    `M72_KEY_X:      btn_x      <= ps2_key[9];
                    `M72_KEY_Y:      btn_y      <= ps2_key[9];
                    `M72_KEY_COIN1:  btn_coin1  <= ps2_key[9];
                    `M72_KEY_COIN2:  btn_coin2  <= ps2_key[9];
                    `M72_KEY_START1: btn_start1 <= ps2_key[9];
                    `M72_KEY_START2: btn_start2 <= ps2_key[9];
                    `M72_KEY_PAUSE:  ;                       // No pause input on this board
                    default:         ;
                endcase
            end
        end
    end

    // Both players share the keyboard, each has its own joystick
    function automatic m72_pkg::player_ctrl_t merge_player(input m72_pkg::joy_t joy);
        m72_pkg::player_ctrl_t ctrl;
        ctrl.up    = ~(btn_up    | joy[3]);
        ctrl.down  = ~(btn_down  | joy[2]);
        ctrl.left  = ~(btn_left  | joy[1]);
        ctrl.right = ~(btn_right | joy[0]);
        ctrl.a     = ~(btn_a     | joy[4]);
        ctrl.b     = ~(btn_b     | joy[5]);
        ctrl.x     = ~(btn_x     | joy[6]);
        ctrl.y     = ~(btn_y     | joy[7]);
        return ctrl;
    endfunction

    assign joy_any = joystick_0 | joystick_1;

    assign panel.p1    = merge_player(joystick_0);
    assign panel.p2    = merge_player(joystick_1);
    assign panel.coin  = {~btn_coin2, ~(btn_coin1 | joy_any[9])};
    assign panel.start = {~(btn_start2 | joy_any[10]), ~(btn_start1 | joy_any[8])};

    //////////////////////////////////////////////////////////////////////
    // DIP switch bank
    //////////////////////////////////////////////////////////////////////

    logic [7:0] dip_mem [`M72_DIP_BANKS];
    logic       dip_wr;

    assign dip_wr = ioctl_wr
                 && (ioctl_index == m72_pkg::dl_index_t'(`M72_DIP_INDEX))
                 && (ioctl_addr < m72_pkg::mem_addr_t'(`M72_DIP_BANKS));

    always_ff @(posedge CLK_32M) begin
        if (dip_wr) begin
            dip_mem[ioctl_addr[dip_aw-1:0]] <= ioctl_dout;
        end
    end

    // Host stores switches active high
    for (genvar i = 0; i < `M72_DIP_OUT; i++) begin : g_dip_out
        assign dip_sw[8*i +: 8] = ~dip_mem[i];
    end

endmodule

/* m72_pkg.sv */
// Request structs assume a byte address and a 16-bit word with two byte enables
`include "m72_defs.svh"

package m72_pkg;

    //////////////////////////////////////////////////////////////////////
    // Plain vectors
    //////////////////////////////////////////////////////////////////////

    typedef logic [`M72_ADDR_W-1:0] mem_addr_t;   // Byte address
    typedef logic [`M72_DATA_W-1:0] mem_data_t;
    typedef logic [`M72_BE_W-1:0]   byte_en_t;
    typedef logic [10:0]            ps2_key_t;    // [10] toggle, [9] pressed, [7:0] code
    typedef logic [15:0]            joy_t;
    typedef logic [7:0]             dl_index_t;

    //////////////////////////////////////////////////////////////////////
    // Grouped signals
    //////////////////////////////////////////////////////////////////////

    // One memory channel request, held until ready
    typedef struct packed {
        mem_addr_t addr;
        mem_data_t wdata;
        byte_en_t  be;
        logic      rnw;     // 1 for read
        logic      req;     // Request level
    } mem_req_t;

    // Active low, as the board samples it
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic x;
        logic y;
    } player_ctrl_t;

    typedef struct packed {
        player_ctrl_t p1;
        player_ctrl_t p2;
        logic [1:0]   coin;   // {coin2, coin1}
        logic [1:0]   start;  // {start2, start1}
    } panel_t;

    // Memory channel owner
    typedef enum logic [1:0] {
        idle,
        rom_busy,
        cpu_busy
    } arb_state_e;

endpackage

/* m72_defs.svh */
// Assumes one download index for ROM bytes and one for DIP bytes, key codes are PS/2 set 2
`ifndef M72_DEFS_SVH
`define M72_DEFS_SVH

// Memory channel geometry
`define M72_ADDR_W      25
`define M72_DATA_W      16
`define M72_BE_W        2

// Host download indices
`define M72_ROM_INDEX   0
`define M72_DIP_INDEX   254

// DIP switch storage
`define M72_DIP_BANKS   8
`define M72_DIP_OUT     2      // Banks handed to the board

// Keyboard scan codes
`define M72_KEY_START1  8'h16  // 1
`define M72_KEY_START2  8'h1E  // 2
`define M72_KEY_COIN1   8'h2E  // 5
`define M72_KEY_COIN2   8'h36  // 6
`define M72_KEY_PAUSE   8'h4D  // P
`define M72_KEY_UP      8'h75
`define M72_KEY_DOWN    8'h72
`define M72_KEY_LEFT    8'h6B
`define M72_KEY_RIGHT   8'h74
`define M72_KEY_A       8'h14  // Ctrl
`define M72_KEY_B       8'h11  // Alt
`define M72_KEY_X       8'h29  // Space
`define M72_KEY_Y       8'h12  // Shift

`endif
